// ==== project.f ====
source/core_pkg.sv
source/fetch_unit.sv
source/id_stage.sv
source/ex_stage.sv
source/regs.sv
source/ctrl.sv
source/core.sv
verification/core_assertions.sv
verification/core_tb.sv

// ==== source/core.sv ====
// core top level
// in-order pipelined RV32I subset core: fetch, decode, execute/memory
// and write-back, with branch and stall control.

module core (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   stall_load_i,
	input  logic                   stall_store_i,
	input  core_pkg::instr_t       instr_i,
	input  core_pkg::word_t        data_mem_i,
	output logic                   mem_wr_en_o,
	output logic                   mem_rd_en_o,
	output logic                   instr_rd_en_o,
	output core_pkg::word_t        data_mem_wr_o,
	output core_pkg::mem_addr_t    addr_mem_wr_o,
	output core_pkg::mem_addr_t    addr_mem_rd_o,
	output core_pkg::mem_addr_t    pc_o
);
	import core_pkg::*;

	hold_code_e hold_code;
	logic       jmp_en;
	mem_addr_t  jmp_to;
	mem_addr_t  jmp_to_id;
	jmp_flag_e  jmp_flag;
	instr_t     instr_id;
	mem_addr_t  pc_id;
	reg_addr_t  addr_rs1;
	reg_addr_t  addr_rs2;
	word_t      data_rs1;
	word_t      data_rs2;
	word_t      jmpb_rs1;
	word_t      jmpb_rs2;
	alu_op_e    alu_operation;
	word_t      alu_op_num1;
	word_t      alu_op_num2;
	word_t      data_rs2_ex;
	reg_addr_t  addr_wr_ex;
	logic       reg_wr_en_ex;
	logic       load;
	logic       store;
	word_t      alu_result;
	reg_addr_t  addr_reg_wr;
	word_t      data_reg_wr;
	logic       reg_wr_en_wb;

	fetch_unit core_fetch (
		.clk(clk), .arst_n_i(arst_n_i), .hold_code_i(hold_code),
		.jmp_en_i(jmp_en), .jmp_to_i(jmp_to), .instr_i(instr_i),
		.pc_o(pc_o), .instr_rd_en_o(instr_rd_en_o),
		.instr_id_o(instr_id), .pc_id_o(pc_id)
	);

	id_stage core_id (
		.clk(clk), .arst_n_i(arst_n_i), .hold_code_i(hold_code),
		.instr_i(instr_id), .pc_i(pc_id),
		.data_rs1_i(data_rs1), .data_rs2_i(data_rs2), .data_bypass_i(alu_result),
		.addr_rs1_o(addr_rs1), .addr_rs2_o(addr_rs2),
		.jmpb_rs1_o(jmpb_rs1), .jmpb_rs2_o(jmpb_rs2),
		.jmp_to_o(jmp_to_id), .jmp_flag_o(jmp_flag),
		.alu_operation_o(alu_operation), .alu_op_num1_o(alu_op_num1),
		.alu_op_num2_o(alu_op_num2), .data_rs2_o(data_rs2_ex),
		.addr_wr_o(addr_wr_ex), .reg_wr_en_o(reg_wr_en_ex),
		.load_o(load), .store_o(store)
	);

	ex_stage core_ex (
		.clk(clk), .arst_n_i(arst_n_i), .hold_code_i(hold_code),
		.alu_operation_i(alu_operation), .alu_op_num1_i(alu_op_num1),
		.alu_op_num2_i(alu_op_num2), .data_rs2_i(data_rs2_ex),
		.addr_wr_i(addr_wr_ex), .reg_wr_en_i(reg_wr_en_ex),
		.load_i(load), .store_i(store), .data_mem_i(data_mem_i),
		.alu_result_o(alu_result),
		.mem_wr_en_o(mem_wr_en_o), .mem_rd_en_o(mem_rd_en_o),
		.data_mem_wr_o(data_mem_wr_o),
		.addr_mem_wr_o(addr_mem_wr_o), .addr_mem_rd_o(addr_mem_rd_o),
		.addr_reg_wr_o(addr_reg_wr), .data_reg_wr_o(data_reg_wr),
		.reg_wr_en_o(reg_wr_en_wb)
	);

	regs general_regs (
		.clk(clk), .arst_n_i(arst_n_i),
		.wr_en_i(reg_wr_en_wb), .addr_wr_i(addr_reg_wr), .data_wr_i(data_reg_wr),
		.addr_rd1_i(addr_rs1), .addr_rd2_i(addr_rs2),
		.data_rd1_o(data_rs1), .data_rd2_o(data_rs2)
	);

	ctrl core_ctrl (
		.stall_load_i(stall_load_i), .stall_store_i(stall_store_i),
		.mem_rd_en_i(mem_rd_en_o), .mem_wr_en_i(mem_wr_en_o),
		.jmp_flag_i(jmp_flag), .data_rs1_i(jmpb_rs1), .data_rs2_i(jmpb_rs2),
		.jmp_to_i(jmp_to_id),
		.jmp_en_o(jmp_en), .jmp_to_o(jmp_to), .hold_code_o(hold_code)
	);

endmodule

// ==== source/core_pkg.sv ====
// core package
// shared widths, instruction encodings and the pipeline control enums
// for the five-block RV32I subset core.

package core_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0]     mem_addr_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [31:0]     instr_t;
	typedef logic [6:0]      opcode_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_pass_b
	} alu_op_e;

	// hold_all freezes pc, IF/ID and ID/EX.
	typedef enum logic [1:0] {
		hold_none, hold_flush, hold_all
	} hold_code_e;

	typedef enum logic [1:0] {
		jmp_none, jmp_beq, jmp_bne, jmp_jal
	} jmp_flag_e;

	localparam mem_addr_t reset_vector = 32'h0000_0000;
	// addi x0, x0, 0.
	localparam instr_t    nop_instr    = 32'h0000_0013;

	localparam opcode_t op_reg    = 7'b0110011;
	localparam opcode_t op_imm    = 7'b0010011;
	localparam opcode_t op_lui    = 7'b0110111;
	localparam opcode_t op_load   = 7'b0000011;
	localparam opcode_t op_store  = 7'b0100011;
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_jal    = 7'b1101111;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;
	localparam logic [2:0] f3_word    = 3'b010;
	localparam logic [2:0] f3_beq     = 3'b000;
	localparam logic [2:0] f3_bne     = 3'b001;
	localparam logic [6:0] f7_base    = 7'b0000000;
	localparam logic [6:0] f7_sub     = 7'b0100000;

endpackage

// ==== source/ctrl.sv ====
// pipeline control
// resolves branches and jumps in decode and turns memory stalls
// into a freeze of the whole pipeline.

module ctrl (
	input  logic                   stall_load_i,
	input  logic                   stall_store_i,
	input  logic                   mem_rd_en_i,
	input  logic                   mem_wr_en_i,
	input  core_pkg::jmp_flag_e    jmp_flag_i,
	input  core_pkg::word_t        data_rs1_i,
	input  core_pkg::word_t        data_rs2_i,
	input  core_pkg::mem_addr_t    jmp_to_i,
	output logic                   jmp_en_o,
	output core_pkg::mem_addr_t    jmp_to_o,
	output core_pkg::hold_code_e   hold_code_o
);
	import core_pkg::*;

	logic mem_stall;
	logic taken;

	assign mem_stall = (stall_load_i && mem_rd_en_i) || (stall_store_i && mem_wr_en_i);

	always_comb begin
		case (jmp_flag_i)
			jmp_beq: taken = (data_rs1_i == data_rs2_i);
			jmp_bne: taken = (data_rs1_i != data_rs2_i);
			jmp_jal: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// a stalled access outranks the redirect, which retries afterwards.
	always_comb begin
		if (mem_stall)
			hold_code_o = hold_all;
		else if (taken)
			hold_code_o = hold_flush;
		else
			hold_code_o = hold_none;
	end

	assign jmp_en_o = taken && !mem_stall;
	assign jmp_to_o = jmp_to_i;

endmodule

// ==== source/ex_stage.sv ====
// execute and memory stage
// alu, data memory access and the EX/WB register feeding the
// register file write port.

module ex_stage (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  core_pkg::hold_code_e   hold_code_i,
	input  core_pkg::alu_op_e      alu_operation_i,
	input  core_pkg::word_t        alu_op_num1_i,
	input  core_pkg::word_t        alu_op_num2_i,
	input  core_pkg::word_t        data_rs2_i,
	input  core_pkg::reg_addr_t    addr_wr_i,
	input  logic                   reg_wr_en_i,
	input  logic                   load_i,
	input  logic                   store_i,
	input  core_pkg::word_t        data_mem_i,
	output core_pkg::word_t        alu_result_o,
	output logic                   mem_wr_en_o,
	output logic                   mem_rd_en_o,
	output core_pkg::word_t        data_mem_wr_o,
	output core_pkg::mem_addr_t    addr_mem_wr_o,
	output core_pkg::mem_addr_t    addr_mem_rd_o,
	output core_pkg::reg_addr_t    addr_reg_wr_o,
	output core_pkg::word_t        data_reg_wr_o,
	output logic                   reg_wr_en_o
);
	import core_pkg::*;

	word_t alu_out;

	always_comb begin
		case (alu_operation_i)
			alu_add:    alu_out = alu_op_num1_i + alu_op_num2_i;
			alu_sub:    alu_out = alu_op_num1_i - alu_op_num2_i;
			alu_and:    alu_out = alu_op_num1_i & alu_op_num2_i;
			alu_or:     alu_out = alu_op_num1_i | alu_op_num2_i;
			alu_xor:    alu_out = alu_op_num1_i ^ alu_op_num2_i;
			alu_pass_b: alu_out = alu_op_num2_i;
			default:    alu_out = alu_op_num2_i;
		endcase
	end

	// loads forward the memory word so decode sees the real value.
	assign alu_result_o = load_i ? data_mem_i : alu_out;

	assign mem_rd_en_o   = load_i;
	assign mem_wr_en_o   = store_i;
	assign addr_mem_rd_o = alu_out;
	assign addr_mem_wr_o = alu_out;
	assign data_mem_wr_o = data_rs2_i;

	// a held access must not write back until memory releases it.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			reg_wr_en_o <= 1'b0;
		else
			reg_wr_en_o <= reg_wr_en_i && (hold_code_i != hold_all);
	end

	always_ff @(posedge clk) begin
		if (hold_code_i != hold_all) begin
			addr_reg_wr_o <= addr_wr_i;
			data_reg_wr_o <= alu_result_o;
		end
	end

endmodule

// ==== source/fetch_unit.sv ====
// fetch unit
// program counter and the IF/ID register. a flush loads a no-op
// in place of the wrong-path word.

module fetch_unit (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  core_pkg::hold_code_e   hold_code_i,
	input  logic                   jmp_en_i,
	input  core_pkg::mem_addr_t    jmp_to_i,
	input  core_pkg::instr_t       instr_i,
	output core_pkg::mem_addr_t    pc_o,
	output logic                   instr_rd_en_o,
	output core_pkg::instr_t       instr_id_o,
	output core_pkg::mem_addr_t    pc_id_o
);
	import core_pkg::*;

	assign instr_rd_en_o = arst_n_i && (hold_code_i != hold_all);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_o <= reset_vector;
		end else if (hold_code_i != hold_all) begin
			if (jmp_en_i)
				pc_o <= jmp_to_i;
			else
				pc_o <= pc_o + 32'd4;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			instr_id_o <= nop_instr;
			pc_id_o    <= reset_vector;
		end else if (hold_code_i != hold_all) begin
			// masked word keeps its pc, only the opcode is dropped.
			instr_id_o <= (hold_code_i == hold_flush) ? nop_instr : instr_i;
			pc_id_o    <= pc_o;
		end
	end

endmodule

// ==== source/id_stage.sv ====
// decode stage
// decodes the RV32I subset, bypasses the ex result into both operands
// and registers the decoded operation into ID/EX.

module id_stage (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  core_pkg::hold_code_e   hold_code_i,
	input  core_pkg::instr_t       instr_i,
	input  core_pkg::mem_addr_t    pc_i,
	input  core_pkg::word_t        data_rs1_i,
	input  core_pkg::word_t        data_rs2_i,
	input  core_pkg::word_t        data_bypass_i,
	output core_pkg::reg_addr_t    addr_rs1_o,
	output core_pkg::reg_addr_t    addr_rs2_o,
	output core_pkg::word_t        jmpb_rs1_o,
	output core_pkg::word_t        jmpb_rs2_o,
	output core_pkg::mem_addr_t    jmp_to_o,
	output core_pkg::jmp_flag_e    jmp_flag_o,
	output core_pkg::alu_op_e      alu_operation_o,
	output core_pkg::word_t        alu_op_num1_o,
	output core_pkg::word_t        alu_op_num2_o,
	output core_pkg::word_t        data_rs2_o,
	output core_pkg::reg_addr_t    addr_wr_o,
	output logic                   reg_wr_en_o,
	output logic                   load_o,
	output logic                   store_o
);
	import core_pkg::*;

	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_addr_t  rd;
	word_t      rs1_val;
	word_t      rs2_val;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_j;
	word_t      imm_u;
	alu_op_e    alu_op_d;
	word_t      num1_d;
	word_t      num2_d;
	logic       wr_en_d;
	logic       load_d;
	logic       store_d;

	assign funct3     = instr_i[14:12];
	assign funct7     = instr_i[31:25];
	assign rd         = instr_i[11:7];
	assign addr_rs1_o = instr_i[19:15];
	assign addr_rs2_o = instr_i[24:20];

	// result of the instruction now in ex wins over the register file.
	assign rs1_val = (reg_wr_en_o && addr_wr_o == addr_rs1_o) ? data_bypass_i : data_rs1_i;
	assign rs2_val = (reg_wr_en_o && addr_wr_o == addr_rs2_o) ? data_bypass_i : data_rs2_i;
	assign jmpb_rs1_o = rs1_val;
	assign jmpb_rs2_o = rs2_val;

	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
		instr_i[11:8], 1'b0};
	assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
		instr_i[30:21], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};

	always_comb begin
		alu_op_d   = alu_add;
		num1_d     = rs1_val;
		num2_d     = rs2_val;
		wr_en_d    = 1'b0;
		load_d     = 1'b0;
		store_d    = 1'b0;
		jmp_flag_o = jmp_none;
		jmp_to_o   = pc_i + imm_b;
		case (instr_i[6:0])
			op_reg: begin
				wr_en_d = (funct7 == f7_base) || (funct7 == f7_sub && funct3 == f3_add_sub);
				case (funct3)
					f3_add_sub: alu_op_d = (funct7 == f7_sub) ? alu_sub : alu_add;
					f3_xor:     alu_op_d = alu_xor;
					f3_or:      alu_op_d = alu_or;
					f3_and:     alu_op_d = alu_and;
					default:    wr_en_d = 1'b0;
				endcase
			end
			op_imm: begin
				num2_d  = imm_i;
				wr_en_d = (funct3 == f3_add_sub);
			end
			op_lui: begin
				alu_op_d = alu_pass_b;
				num2_d   = imm_u;
				wr_en_d  = 1'b1;
			end
			op_load: begin
				num2_d  = imm_i;
				load_d  = (funct3 == f3_word);
				wr_en_d = load_d;
			end
			op_store: begin
				num2_d  = imm_s;
				store_d = (funct3 == f3_word);
			end
			op_branch: begin
				if (funct3 == f3_beq)
					jmp_flag_o = jmp_beq;
				else if (funct3 == f3_bne)
					jmp_flag_o = jmp_bne;
			end
			op_jal: begin
				// link value rides through the alu.
				alu_op_d   = alu_pass_b;
				num2_d     = pc_i + 32'd4;
				wr_en_d    = 1'b1;
				jmp_flag_o = jmp_jal;
				jmp_to_o   = pc_i + imm_j;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			alu_operation_o <= alu_add;
			reg_wr_en_o     <= 1'b0;
			load_o          <= 1'b0;
			store_o         <= 1'b0;
		end else if (hold_code_i != hold_all) begin
			alu_operation_o <= alu_op_d;
			reg_wr_en_o     <= wr_en_d && (rd != 5'd0);
			load_o          <= load_d;
			store_o         <= store_d;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_code_i != hold_all) begin
			alu_op_num1_o <= num1_d;
			alu_op_num2_o <= num2_d;
			data_rs2_o    <= rs2_val;
			addr_wr_o     <= rd;
		end
	end

endmodule

// ==== source/regs.sv ====
// register file
// 32 x 32 bit, x0 reads as zero, a read of the register being
// written returns the new value.

module regs (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   wr_en_i,
	input  core_pkg::reg_addr_t    addr_wr_i,
	input  core_pkg::word_t        data_wr_i,
	input  core_pkg::reg_addr_t    addr_rd1_i,
	input  core_pkg::reg_addr_t    addr_rd2_i,
	output core_pkg::word_t        data_rd1_o,
	output core_pkg::word_t        data_rd2_o
);
	import core_pkg::*;

	word_t rf [32];
	logic  wr_live;

	assign wr_live = wr_en_i && (addr_wr_i != 5'd0);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++)
				rf[i] <= '0;
		end else if (wr_live) begin
			rf[addr_wr_i] <= data_wr_i;
		end
	end

	assign data_rd1_o = (wr_live && addr_wr_i == addr_rd1_i) ? data_wr_i : rf[addr_rd1_i];
	assign data_rd2_o = (wr_live && addr_wr_i == addr_rd2_i) ? data_wr_i : rf[addr_rd2_i];

endmodule

// ==== verification/core_assertions.sv ====
// core interface checks
// bound to the core. checks exclusive memory enables, pc alignment
// and that a stalled access holds still.

module core_assertions (
	input logic                  clk,
	input logic                  arst_n_i,
	input logic                  stall_load_i,
	input logic                  stall_store_i,
	input logic                  mem_wr_en_o,
	input logic                  mem_rd_en_o,
	input core_pkg::mem_addr_t   pc_o,
	input core_pkg::mem_addr_t   addr_mem_wr_o,
	input core_pkg::mem_addr_t   addr_mem_rd_o,
	input core_pkg::word_t       data_mem_wr_o
);
	timeunit 1ns;
	timeprecision 100ps;

	int assert_errors = 0;

	excl_access: assert property (@(posedge clk) disable iff (!arst_n_i)
		!(mem_wr_en_o && mem_rd_en_o))
		else begin
			$error("load and store enables are high together");
			assert_errors++;
		end

	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
		pc_o[1:0] == 2'b00)
		else begin
			$error("pc is not word aligned");
			assert_errors++;
		end

	// held access keeps pc and the memory outputs.
	load_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_rd_en_o && stall_load_i |=> mem_rd_en_o && $stable(pc_o) && $stable(addr_mem_rd_o))
		else begin
			$error("stalled load did not hold");
			assert_errors++;
		end

	store_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_wr_en_o && stall_store_i |=> mem_wr_en_o && $stable(pc_o)
		&& $stable(addr_mem_wr_o) && $stable(data_mem_wr_o))
		else begin
			$error("stalled store did not hold");
			assert_errors++;
		end

endmodule

// ==== verification/core_tb.sv ====
// core testbench
// memory models, a small assembler and directed programs that end
// with a store to a sentinel address.

module core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam mem_addr_t sentinel_addr = 32'h0000_03fc;
	localparam int        run_limit     = 400;

	logic      clk;
	logic      arst_n_i;
	logic      stall_load_i;
	logic      stall_store_i;
	instr_t    instr_i;
	word_t     data_mem_i;
	logic      mem_wr_en_o;
	logic      mem_rd_en_o;
	logic      instr_rd_en_o;
	word_t     data_mem_wr_o;
	mem_addr_t addr_mem_wr_o;
	mem_addr_t addr_mem_rd_o;
	mem_addr_t pc_o;

	instr_t      imem [256];
	word_t       dmem [256];
	instr_t      prog [$];
	mem_addr_t   exp_addr [$];
	word_t       exp_data [$];
	mem_addr_t   st_addr [$];
	word_t       st_data [$];
	mem_addr_t   pc_trace [$];
	logic        acc_trace [$];
	logic [31:0] rng_state = 32'h7d43ecb6;
	bit          stall_on;
	int          stall_cycles;

	// both memories answer in the same cycle.
	assign instr_i    = imem[pc_o[9:2]];
	assign data_mem_i = dmem[addr_mem_rd_o[9:2]];

	core uut (
		.clk(clk), .arst_n_i(arst_n_i), .stall_load_i(stall_load_i),
		.stall_store_i(stall_store_i), .instr_i(instr_i), .data_mem_i(data_mem_i),
		.mem_wr_en_o(mem_wr_en_o), .mem_rd_en_o(mem_rd_en_o),
		.instr_rd_en_o(instr_rd_en_o), .data_mem_wr_o(data_mem_wr_o),
		.addr_mem_wr_o(addr_mem_wr_o), .addr_mem_rd_o(addr_mem_rd_o), .pc_o(pc_o)
	);

	bind core core_assertions core_checks (
		.clk(clk), .arst_n_i(arst_n_i), .stall_load_i(stall_load_i),
		.stall_store_i(stall_store_i), .mem_wr_en_o(mem_wr_en_o),
		.mem_rd_en_o(mem_rd_en_o), .pc_o(pc_o), .addr_mem_wr_o(addr_mem_wr_o),
		.addr_mem_rd_o(addr_mem_rd_o), .data_mem_wr_o(data_mem_wr_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	function automatic word_t sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic word_t fill_word(input mem_addr_t a);
		return a ^ (a << 16) ^ 32'h9e37_79b9;
	endfunction

	function automatic instr_t alu_rr(input logic [6:0] f7, input logic [2:0] f3,
		input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic instr_t addi(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, f3_add_sub, rd, op_imm};
	endfunction

	function automatic instr_t lui(input reg_addr_t rd, input logic [19:0] imm);
		return {imm, rd, op_lui};
	endfunction

	function automatic instr_t lw(input reg_addr_t rd, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm, rs1, f3_word, rd, op_load};
	endfunction

	function automatic instr_t sw(input reg_addr_t rs2, input reg_addr_t rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
	endfunction

	function automatic instr_t branch(input logic [2:0] f3, input reg_addr_t rs1,
		input reg_addr_t rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic instr_t jal(input reg_addr_t rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	task automatic abort_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %08h expected %08h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %08h expected %08h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
			abort_run();
		end
	endtask

	// random stall levels, only seen by the core during an access.
	always @(posedge clk) begin
		if (stall_on) begin
			void'(next_rand());
			stall_load_i  <= rng_state[3];
			stall_store_i <= rng_state[9];
		end else begin
			stall_load_i  <= 1'b0;
			stall_store_i <= 1'b0;
		end
	end

	always @(negedge clk) begin
		if (uut.core_checks.assert_errors != 0) begin
			$display("a bound assertion on the core failed");
			abort_run();
		end
	end

	task automatic run_prog(input bit stall_en);
		int  cycles;
		bit  done;
		bit  stalled;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : nop_instr;
			dmem[i] = fill_word(mem_addr_t'(i) << 2);
		end
		st_addr.delete();
		st_data.delete();
		pc_trace.delete();
		acc_trace.delete();
		stall_on = stall_en;
		@(posedge clk);
		arst_n_i <= 1'b0;
		repeat (5) begin
			@(negedge clk);
			check_bit("instr_rd_en_o", instr_rd_en_o, 1'b0);
			@(posedge clk);
		end
		arst_n_i <= 1'b1;
		cycles = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk);
			pc_trace.push_back(pc_o);
			acc_trace.push_back(mem_rd_en_o || mem_wr_en_o);
			stalled = (mem_rd_en_o && stall_load_i) || (mem_wr_en_o && stall_store_i);
			// fetch pauses only while the memory holds an access.
			check_bit("instr_rd_en_o", instr_rd_en_o, !stalled);
			if (stalled) begin
				stall_cycles++;
			end else if (mem_wr_en_o) begin
				if (addr_mem_wr_o == sentinel_addr) begin
					done = 1'b1;
				end else begin
					st_addr.push_back(addr_mem_wr_o);
					st_data.push_back(data_mem_wr_o);
					dmem[addr_mem_wr_o[9:2]] = data_mem_wr_o;
				end
			end
			cycles++;
			if (cycles > run_limit) begin
				$display("timeout, no sentinel store within %0d cycles", run_limit);
				abort_run();
			end
		end
		stall_on = 1'b0;
	endtask

	task automatic check_stores();
		if (st_addr.size() != exp_addr.size()) begin
			$display("saw %0d stores, expected %0d", st_addr.size(), exp_addr.size());
			abort_run();
		end
		foreach (exp_addr[i]) begin
			check_addr("addr_mem_wr_o", st_addr[i], exp_addr[i]);
			check_word("data_mem_wr_o", st_data[i], exp_data[i]);
		end
	endtask

	task automatic check_redirect(input mem_addr_t from_pc, input mem_addr_t to_pc);
		int hit;
		hit = -1;
		foreach (pc_trace[i]) begin
			if (hit < 0 && pc_trace[i] == from_pc)
				hit = i;
		end
		if (hit < 0 || hit + 2 >= pc_trace.size()) begin
			$display("pc %08h was never fetched before the sentinel store", from_pc);
			abort_run();
		end
		check_addr("pc_o", pc_trace[hit + 2], to_pc);
	endtask

	task automatic build_alu_prog();
		logic [31:0] r1;
		logic [31:0] r2;
		word_t       a;
		word_t       b;
		r1 = next_rand();
		r2 = next_rand();
		a  = {r1[31:12], 12'b0} + sext12(r1[11:0]);
		b  = {r2[31:12], 12'b0} + sext12(r2[11:0]);
		prog = {lui(1, r1[31:12]), addi(1, 1, r1[11:0]), lui(2, r2[31:12]),
			addi(2, 2, r2[11:0]),
			alu_rr(f7_base, f3_add_sub, 3, 1, 2), sw(3, 0, 0),
			alu_rr(f7_sub, f3_add_sub, 4, 1, 2), sw(4, 0, 4),
			alu_rr(f7_base, f3_and, 5, 1, 2), sw(5, 0, 8),
			alu_rr(f7_base, f3_or, 6, 1, 2), sw(6, 0, 12),
			alu_rr(f7_base, f3_xor, 7, 1, 2), sw(7, 0, 16), sw(0, 0, sentinel_addr[11:0])};
		exp_addr = {32'd0, 32'd4, 32'd8, 32'd12, 32'd16};
		exp_data = {a + b, a - b, a & b, a | b, a ^ b};
	endtask

	task automatic build_bypass_prog();
		logic [31:0] r;
		word_t       a;
		word_t       b;
		word_t       c;
		r = next_rand();
		a = sext12(r[11:0]);
		b = a + sext12(r[23:12]);
		c = a + b;
		prog = {addi(1, 0, r[11:0]), addi(2, 1, r[23:12]),
			alu_rr(f7_base, f3_add_sub, 3, 1, 2), alu_rr(f7_sub, f3_add_sub, 4, 3, 1),
			sw(4, 0, 32), sw(3, 0, 36), sw(2, 0, 40), sw(0, 0, sentinel_addr[11:0])};
		exp_addr = {32'd32, 32'd36, 32'd40};
		exp_data = {c - a, c, b};
	endtask

	task automatic build_load_prog();
		logic [31:0] r;
		word_t       a;
		word_t       m;
		r = next_rand();
		a = sext12(r[11:0]);
		m = fill_word(32'd64);
		prog = {addi(1, 0, r[11:0]), lw(2, 0, 64), alu_rr(f7_base, f3_add_sub, 3, 2, 1),
			sw(3, 0, 68), sw(2, 0, 72), addi(0, 0, r[11:0]),
			alu_rr(f7_base, f3_add_sub, 0, 1, 1), sw(0, 0, 76), lw(4, 0, 68), sw(4, 0, 80),
			sw(0, 0, sentinel_addr[11:0])};
		exp_addr = {32'd68, 32'd72, 32'd76, 32'd80};
		exp_data = {m + a, m, 32'd0, m + a};
	endtask

	task automatic build_branch_prog();
		logic [31:0] r;
		logic [11:0] lo;
		r  = next_rand();
		// nonzero so the compares against x0 are known.
		lo = r[11:0] | 12'h001;
		// taken targets skip two words, so a late or missing redirect shows in pc_o.
		prog = {addi(1, 0, lo), addi(2, 0, lo), branch(f3_beq, 1, 2, 12), sw(1, 0, 100),
			sw(2, 0, 100), branch(f3_bne, 1, 2, 8), sw(1, 0, 104), branch(f3_bne, 1, 0, 12),
			sw(1, 0, 108), sw(2, 0, 108), branch(f3_beq, 1, 0, 8), sw(2, 0, 112),
			jal(5, 12), sw(1, 0, 116), sw(1, 0, 120), sw(5, 0, 124),
			sw(0, 0, sentinel_addr[11:0])};
		exp_addr = {32'd104, 32'd112, 32'd124};
		exp_data = {sext12(lo), sext12(lo), 32'd52};
	endtask

	task automatic compare_stalled_run();
		mem_addr_t ref_addr [$];
		word_t     ref_data [$];
		run_prog(1'b0);
		ref_addr = st_addr;
		ref_data = st_data;
		run_prog(1'b1);
		if (st_addr.size() != ref_addr.size()) begin
			$display("stalled run made %0d stores, unstalled run %0d",
				st_addr.size(), ref_addr.size());
			abort_run();
		end
		foreach (ref_addr[i]) begin
			check_addr("addr_mem_wr_o", st_addr[i], ref_addr[i]);
			check_word("data_mem_wr_o", st_data[i], ref_data[i]);
		end
		check_stores();
	endtask

	task automatic reset_test();
		build_bypass_prog();
		run_prog(1'b0);
		check_addr("pc_o", pc_trace[0], 32'h0000_0000);
		// first store is the fifth word, in execute at cycle 6.
		for (int i = 0; i < 6; i++)
			check_bit("mem_rd_en_o | mem_wr_en_o", acc_trace[i], 1'b0);
		check_bit("mem_rd_en_o | mem_wr_en_o", acc_trace[6], 1'b1);
	endtask

	task automatic alu_ops_test();
		build_alu_prog();
		run_prog(1'b0);
		check_stores();
	endtask

	task automatic bypass_test();
		build_bypass_prog();
		run_prog(1'b0);
		check_stores();
	endtask

	task automatic load_use_test();
		build_load_prog();
		run_prog(1'b0);
		check_stores();
	endtask

	task automatic branch_test();
		build_branch_prog();
		run_prog(1'b0);
		check_stores();
		check_redirect(32'd8, 32'd20);
		check_redirect(32'd28, 32'd40);
		check_redirect(32'd48, 32'd60);
	endtask

	task automatic stall_test();
		stall_cycles = 0;
		build_load_prog();
		compare_stalled_run();
		build_branch_prog();
		compare_stalled_run();
		build_alu_prog();
		compare_stalled_run();
		if (stall_cycles == 0) begin
			$display("no memory access was ever stalled");
			abort_run();
		end
	endtask

	initial begin
		arst_n_i      = 1'b0;
		stall_load_i  = 1'b0;
		stall_store_i = 1'b0;
		stall_on      = 1'b0;
		stall_cycles  = 0;
		reset_test();
		alu_ops_test();
		bypass_test();
		load_use_test();
		branch_test();
		stall_test();
		if (uut.core_checks.assert_errors != 0) begin
			$display("a bound assertion on the core failed");
			abort_run();
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule
